//--- common/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
`define ICACHE_WAYS        2
`define ICACHE_SETS        128
`define ICACHE_LINE_WORDS  8

`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32

// pc bit positions
`define ICACHE_INDEX_LO    5
`define ICACHE_INDEX_HI    11
`define ICACHE_TAG_LO      12
`define ICACHE_PAIR_LO     3

// derived widths
`define ICACHE_INDEX_W     (`ICACHE_INDEX_HI - `ICACHE_INDEX_LO + 1)
`define ICACHE_PAIR_W      (`ICACHE_INDEX_HI - `ICACHE_PAIR_LO + 1)
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_TAG_LO)
`define ICACHE_BEAT_W      $clog2(`ICACHE_LINE_WORDS)

`endif

//--- common/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    // word 0 sits at pc, word 1 at pc+4
    typedef logic [1:0][`ICACHE_WORD_W-1:0] insn_pair_t;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] pc;
        insn_pair_t                insts;
    } fetch_rsp_t;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // line aligned burst address
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [`ICACHE_INDEX_W-1:0] index;
        logic [`ICACHE_WAYS-1:0]    way;
    } inv_req_t;

    typedef struct packed {
        logic [`ICACHE_WAYS-1:0]   way;
        logic [`ICACHE_PAIR_W-1:0] pair_addr;
        insn_pair_t                data;
        tag_entry_t                tag;
        logic                      tag_we;
        logic                      data_we;
    } array_wr_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ADDR,
        CTRL_FILL,
        CTRL_DONE
    } ctrl_state_e;

endpackage

//--- dv/tb_icache.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module tb_icache
    import icache_pkg::*;
();

    localparam int NUM_OPS    = 400;
    localparam int CLK_PERIOD = 40;
    // worst miss is about 80 cycles with random gaps and stalls
    localparam int TIMEOUT_NS = NUM_OPS * 80 * CLK_PERIOD + 20000;

    logic                      clk;
    logic                      rst_n;
    logic                      req_valid;
    logic                      req_ready;
    fetch_req_t                req;
    logic                      rsp_valid;
    logic                      rsp_ready;
    fetch_rsp_t                rsp;
    logic                      inv_valid;
    logic                      inv_ready;
    inv_req_t                  inv;
    logic                      mem_req_valid;
    logic                      mem_req_ready;
    mem_req_t                  mem_req;
    logic                      mem_data_valid;
    logic [`ICACHE_WORD_W-1:0] mem_data;

    // cache model
    logic [`ICACHE_TAG_W-1:0] model_tag [`ICACHE_SETS][`ICACHE_WAYS];
    logic                     model_valid [`ICACHE_SETS][`ICACHE_WAYS];
    logic                     model_repl [`ICACHE_SETS];

    fetch_rsp_t                exp_rsp_q[$];
    logic [`ICACHE_ADDR_W-1:0] exp_mem_q[$];
    logic [31:0]               rng;

    icache_top i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid_i      (req_valid),
        .req_ready_o      (req_ready),
        .req_i            (req),
        .rsp_valid_o      (rsp_valid),
        .rsp_ready_i      (rsp_ready),
        .rsp_o            (rsp),
        .inv_valid_i      (inv_valid),
        .inv_ready_o      (inv_ready),
        .inv_i            (inv),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_o        (mem_req),
        .mem_data_valid_i (mem_data_valid),
        .mem_data_i       (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all fetches completed");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory word is a hash of its byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = xorshift32(addr ^ 32'h5bd1e995);
        x = xorshift32(x ^ 32'h01234567);
        return x;
    endfunction

    function automatic logic [`ICACHE_TAG_W-1:0] pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return 20'h00010;
            2'd1:    return 20'h00023;
            2'd2:    return 20'h0004a;
            default: return 20'h00ff1;
        endcase
    endfunction

    function automatic logic [`ICACHE_INDEX_W-1:0] pick_set(input logic [1:0] sel);
        case (sel)
            2'd0:    return 7'd3;
            2'd1:    return 7'd40;
            2'd2:    return 7'd77;
            default: return 7'd127;
        endcase
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // model lookup at the accepting edge with refill on a predicted miss
    task automatic predict_fetch(input logic [31:0] pc);
        logic [`ICACHE_INDEX_W-1:0] set;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic                       hit;
        int                         victim;
        fetch_rsp_t                 e;
        set = pc[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
        tag = pc[`ICACHE_ADDR_W-1:`ICACHE_TAG_LO];
        hit = (model_valid[set][0] && model_tag[set][0] == tag) ||
              (model_valid[set][1] && model_tag[set][1] == tag);
        if (!hit) begin
            victim = model_repl[set] ? 1 : 0;
            model_tag[set][victim]   = tag;
            model_valid[set][victim] = 1'b1;
            model_repl[set]          = ~model_repl[set];
            exp_mem_q.push_back({pc[31:5], 5'b00000});
        end
        e.pc       = pc;
        e.insts[0] = mem_word(pc);
        e.insts[1] = mem_word(pc + 32'd4);
        exp_rsp_q.push_back(e);
    endtask

    initial begin
        int                         issued;
        int                         beats_sent;
        logic                       burst_active;
        logic [31:0]                burst_addr;
        logic                       req_fired;
        logic                       inv_fired;
        logic                       stalled;
        fetch_rsp_t                 held_rsp;
        logic [31:0]                r;
        issued       = 0;
        beats_sent   = 0;
        burst_active = 1'b0;
        burst_addr   = '0;
        req_fired    = 1'b0;
        inv_fired    = 1'b0;
        stalled      = 1'b0;
        held_rsp     = '0;
        rng          = 32'h73d0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        rsp_ready      = 1'b0;
        inv_valid      = 1'b0;
        inv            = '0;
        mem_req_ready  = 1'b0;
        mem_data_valid = 1'b0;
        mem_data       = '0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            model_repl[s] = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_tag[s][w]   = '0;
                model_valid[s][w] = 1'b0;
            end
        end

        repeat (16) begin
            @(posedge clk);
            #1;
            check("reset_req_ready", 128'(1'b0), 128'(req_ready));
            check("reset_rsp_valid", 128'(1'b0), 128'(rsp_valid));
            check("reset_mem_req_valid", 128'(1'b0), 128'(mem_req_valid));
        end
        #1;
        rst_n = 1'b1;

        while (issued < NUM_OPS || req_valid || inv_valid || exp_rsp_q.size() != 0 ||
               burst_active) begin
            @(posedge clk);
            #2;
            if (req_fired) begin
                req_valid = 1'b0;
            end
            if (inv_fired) begin
                inv_valid = 1'b0;
            end

            rng       = xorshift32(rng);
            r         = rng;
            rsp_ready = (r[1:0] != 2'b00);
            mem_req_ready = r[2];

            if (!req_valid && !inv_valid && issued < NUM_OPS) begin
                rng = xorshift32(rng);
                if (rng[3:0] == 4'h0) begin
                    inv_valid = 1'b1;
                    inv.index = pick_set(rng[7:6]);
                    inv.way   = rng[4] ? 2'b10 : 2'b01;
                end else if (rng[5:4] != 2'b00) begin
                    req_valid = 1'b1;
                    req.pc    = {pick_tag(rng[9:8]), pick_set(rng[11:10]), rng[13:12], 3'b000};
                    issued++;
                end
            end

            // eight beats in address order with random gaps
            if (burst_active && r[3]) begin
                mem_data_valid = 1'b1;
                mem_data       = mem_word(burst_addr + 32'(beats_sent * 4));
                beats_sent++;
                if (beats_sent == `ICACHE_LINE_WORDS) begin
                    burst_active = 1'b0;
                end
            end else begin
                mem_data_valid = 1'b0;
            end

            // sample just before the next edge
            #(CLK_PERIOD - 3);
            if (stalled) begin
                check("stall_rsp_valid", 128'(1'b1), 128'(rsp_valid));
                check("stall_rsp", 128'(held_rsp), 128'(rsp));
            end
            // invalidate only opens with no fetch outstanding
            check("inv_ready", 128'(exp_rsp_q.size() == 0), 128'(inv_ready));
            if (rsp_valid && rsp_ready) begin
                if (exp_rsp_q.size() == 0) begin
                    abort_run("response seen with no fetch outstanding");
                end
                check("response", 128'(exp_rsp_q.pop_front()), 128'(rsp));
            end
            stalled = rsp_valid && !rsp_ready;
            if (stalled) begin
                check("stall_req_ready", 128'(1'b0), 128'(req_ready));
                held_rsp = rsp;
            end

            req_fired = req_valid && req_ready;
            inv_fired = inv_valid && inv_ready;
            if (req_fired) begin
                predict_fetch(req.pc);
            end
            if (inv_fired) begin
                model_valid[inv.index][inv.way[1] ? 1 : 0] = 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (exp_mem_q.size() == 0) begin
                    abort_run("memory request issued for a fetch that should hit");
                end
                check("mem_addr", 128'(exp_mem_q.pop_front()), 128'(mem_req.addr));
                burst_active = 1'b1;
                beats_sent   = 0;
                burst_addr   = mem_req.addr;
            end
        end

        if (exp_mem_q.size() != 0) begin
            $display("predicted miss never issued a memory request");
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+common
common/icache_pkg.sv
rtl/sram_1r1w.sv
icache/icache_array.sv
icache/icache_lookup.sv
icache/icache_ctrl.sv
icache/icache_top.sv
dv/tb_icache.sv

//--- icache/icache_array.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_array
    import icache_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                re_i,
    input  logic [`ICACHE_ADDR_W-1:0]           rpc_i,
    output tag_entry_t [`ICACHE_WAYS-1:0]       tags_o,
    output logic [`ICACHE_WAYS-1:0]             valids_o,
    output insn_pair_t [`ICACHE_WAYS-1:0]       data_o,
    input  logic                                wr_valid_i,
    input  array_wr_t                           wr_i,
    input  logic                                inv_valid_i,
    input  inv_req_t                            inv_i,
    output logic [`ICACHE_WAYS-1:0]             victim_o
);

    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;
    logic [`ICACHE_SETS-1:0]                   repl_q;
    logic [`ICACHE_WAYS-1:0]                   rd_valid_q;
    logic [`ICACHE_INDEX_W-1:0]                rd_index;
    logic [`ICACHE_INDEX_W-1:0]                rd_index_q;
    logic [`ICACHE_INDEX_W-1:0]                wr_index;

    assign rd_index = rpc_i[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
    assign wr_index = wr_i.pair_addr[`ICACHE_PAIR_W-1 -: `ICACHE_INDEX_W];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        sram_1r1w #(
            .WIDTH($bits(tag_entry_t)),
            .DEPTH(`ICACHE_SETS)
        ) i_tag_ram (
            .clk     (clk),
            .re_i    (re_i),
            .raddr_i (rd_index),
            .rdata_o (tags_o[w]),
            .we_i    (wr_valid_i && wr_i.tag_we && wr_i.way[w]),
            .waddr_i (wr_index),
            .wdata_i (wr_i.tag)
        );

        // two words per entry, 512 entries
        sram_1r1w #(
            .WIDTH($bits(insn_pair_t)),
            .DEPTH(`ICACHE_SETS * `ICACHE_LINE_WORDS / 2)
        ) i_data_ram (
            .clk     (clk),
            .re_i    (re_i),
            .raddr_i (rpc_i[`ICACHE_INDEX_HI:`ICACHE_PAIR_LO]),
            .rdata_o (data_o[w]),
            .we_i    (wr_valid_i && wr_i.data_we && wr_i.way[w]),
            .waddr_i (wr_i.pair_addr),
            .wdata_i (wr_i.data)
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            repl_q  <= '0;
        end else begin
            // tag write ends a refill
            if (wr_valid_i && wr_i.tag_we) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (wr_i.way[w]) begin
                        valid_q[w][wr_index] <= 1'b1;
                    end
                end
                repl_q[wr_index] <= ~repl_q[wr_index];
            end
            if (inv_valid_i) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (inv_i.way[w]) begin
                        valid_q[w][inv_i.index] <= 1'b0;
                    end
                end
            end
        end
    end

    // valid bits follow the ram read timing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid_q <= '0;
            rd_index_q <= '0;
        end else if (re_i) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                rd_valid_q[w] <= valid_q[w][rd_index];
            end
            rd_index_q <= rd_index;
        end
    end

    assign valids_o = rd_valid_q;

    // one bit per set picks way 1 when set, way 0 otherwise
    assign victim_o = {repl_q[rd_index_q], ~repl_q[rd_index_q]};

endmodule

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // lookup side
    input  logic                      miss_i,
    input  logic [`ICACHE_ADDR_W-1:0] miss_pc_i,
    input  logic [`ICACHE_WAYS-1:0]   victim_i,
    input  logic                      busy_i,
    // memory bus
    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    output mem_req_t                  mem_req_o,
    input  logic                      mem_data_valid_i,
    input  logic [`ICACHE_WORD_W-1:0] mem_data_i,
    // array writes
    output logic                      wr_valid_o,
    output array_wr_t                 wr_o,
    output logic                      fill_done_o,
    // invalidate
    input  logic                      inv_valid_i,
    output logic                      inv_ready_o,
    input  inv_req_t                  inv_i,
    output logic                      inv_valid_o,
    output inv_req_t                  inv_o,
    output logic                      inv_block_o
);

    ctrl_state_e               state_q;
    ctrl_state_e               state_d;
    logic [`ICACHE_BEAT_W-1:0] beat_q;
    logic [`ICACHE_ADDR_W-1:0] line_addr_q;
    logic [`ICACHE_WAYS-1:0]   way_q;
    logic [`ICACHE_WORD_W-1:0] lo_word_q;
    logic                      last_beat;
    logic                      inv_fire;

    assign last_beat = (beat_q == `ICACHE_BEAT_W'(`ICACHE_LINE_WORDS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (miss_i) begin
                    state_d = CTRL_ADDR;
                end
            end
            CTRL_ADDR: begin
                if (mem_req_ready_i) begin
                    state_d = CTRL_FILL;
                end
            end
            CTRL_FILL: begin
                if (mem_data_valid_i && last_beat) begin
                    state_d = CTRL_DONE;
                end
            end
            CTRL_DONE: begin
                state_d = CTRL_IDLE;
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CTRL_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == CTRL_ADDR) begin
                beat_q <= '0;
            end else if (state_q == CTRL_FILL && mem_data_valid_i) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // victim is latched with the miss, the repl bit flips on the last write
    always_ff @(posedge clk) begin
        if (state_q == CTRL_IDLE && miss_i) begin
            line_addr_q <= {miss_pc_i[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LO],
                            {`ICACHE_INDEX_LO{1'b0}}};
            way_q       <= victim_i;
        end
        if (state_q == CTRL_FILL && mem_data_valid_i && !beat_q[0]) begin
            lo_word_q <= mem_data_i;
        end
    end

    assign mem_req_valid_o = (state_q == CTRL_ADDR);
    assign mem_req_o.addr  = line_addr_q;

    // odd beat completes a pair
    assign wr_valid_o = (state_q == CTRL_FILL) && mem_data_valid_i && beat_q[0];

    assign wr_o.way       = way_q;
    assign wr_o.pair_addr = {line_addr_q[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO],
                             beat_q[`ICACHE_BEAT_W-1:1]};
    assign wr_o.data[0]   = lo_word_q;
    assign wr_o.data[1]   = mem_data_i;
    assign wr_o.tag.tag   = line_addr_q[`ICACHE_ADDR_W-1:`ICACHE_TAG_LO];
    assign wr_o.tag_we    = last_beat;
    assign wr_o.data_we   = 1'b1;

    assign fill_done_o = (state_q == CTRL_DONE);

    // invalidates only slip in while nothing is in flight
    assign inv_ready_o = (state_q == CTRL_IDLE) && !busy_i;
    assign inv_fire    = inv_valid_i && inv_ready_o;
    assign inv_valid_o = inv_fire;
    assign inv_o       = inv_i;
    assign inv_block_o = inv_fire;

endmodule

//--- icache/icache_lookup.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    // fetch request
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  fetch_req_t                    req_i,
    // fetch response
    output logic                          rsp_valid_o,
    input  logic                          rsp_ready_i,
    output fetch_rsp_t                    rsp_o,
    // array read
    output logic                          re_o,
    output logic [`ICACHE_ADDR_W-1:0]     rpc_o,
    input  tag_entry_t [`ICACHE_WAYS-1:0] tags_i,
    input  logic [`ICACHE_WAYS-1:0]       valids_i,
    input  insn_pair_t [`ICACHE_WAYS-1:0] data_i,
    // controller
    output logic                          miss_o,
    output logic [`ICACHE_ADDR_W-1:0]     miss_pc_o,
    input  logic                          fill_done_i,
    output logic                          busy_o,
    input  logic                          inv_block_i
);

    logic                      active_q;
    logic                      s2_valid_q;
    logic [`ICACHE_ADDR_W-1:0] s2_pc_q;
    logic [`ICACHE_WAYS-1:0]   hit_way;
    logic                      hit;
    logic                      req_fire;
    logic                      rsp_fire;
    insn_pair_t                hit_data;

    // request side opens after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_cmp
        assign hit_way[w] = valids_i[w] &&
                            (tags_i[w].tag == s2_pc_q[`ICACHE_ADDR_W-1:`ICACHE_TAG_LO]);
    end

    assign hit = |hit_way;

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_way[w]) begin
                hit_data = hit_data | data_i[w];
            end
        end
    end

    assign rsp_valid_o = s2_valid_q && hit;
    assign rsp_fire    = rsp_valid_o && rsp_ready_i;

    // stage 2 frees up on the same edge its response is taken
    assign req_ready_o = active_q && !inv_block_i && (!s2_valid_q || rsp_fire);
    assign req_fire    = req_valid_i && req_ready_o;

    // replay reads the held pc once the line is in
    assign re_o  = req_fire || fill_done_i;
    assign rpc_o = fill_done_i ? s2_pc_q : req_i.pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid_q <= 1'b0;
        end else if (req_fire) begin
            s2_valid_q <= 1'b1;
        end else if (rsp_fire) begin
            s2_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            s2_pc_q <= req_i.pc;
        end
    end

    assign rsp_o.pc    = s2_pc_q;
    assign rsp_o.insts = hit_data;

    assign miss_o    = s2_valid_q && !hit;
    assign miss_pc_o = s2_pc_q;
    assign busy_o    = s2_valid_q;

endmodule

//--- icache/icache_top.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // fetch
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  fetch_req_t                req_i,
    output logic                      rsp_valid_o,
    input  logic                      rsp_ready_i,
    output fetch_rsp_t                rsp_o,
    // commit side invalidate
    input  logic                      inv_valid_i,
    output logic                      inv_ready_o,
    input  inv_req_t                  inv_i,
    // memory
    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    output mem_req_t                  mem_req_o,
    input  logic                      mem_data_valid_i,
    input  logic [`ICACHE_WORD_W-1:0] mem_data_i
);

    logic                      re;
    logic [`ICACHE_ADDR_W-1:0] rpc;
    tag_entry_t [`ICACHE_WAYS-1:0] tags;
    logic [`ICACHE_WAYS-1:0]   valids;
    insn_pair_t [`ICACHE_WAYS-1:0] data;
    logic                      miss;
    logic [`ICACHE_ADDR_W-1:0] miss_pc;
    logic                      fill_done;
    logic                      busy;
    logic                      inv_block;
    logic [`ICACHE_WAYS-1:0]   victim;
    logic                      wr_valid;
    array_wr_t                 wr;
    logic                      arr_inv_valid;
    inv_req_t                  arr_inv;

    icache_lookup i_lookup (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .re_o        (re),
        .rpc_o       (rpc),
        .tags_i      (tags),
        .valids_i    (valids),
        .data_i      (data),
        .miss_o      (miss),
        .miss_pc_o   (miss_pc),
        .fill_done_i (fill_done),
        .busy_o      (busy),
        .inv_block_i (inv_block)
    );

    icache_ctrl i_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .miss_i           (miss),
        .miss_pc_i        (miss_pc),
        .victim_i         (victim),
        .busy_i           (busy),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .wr_valid_o       (wr_valid),
        .wr_o             (wr),
        .fill_done_o      (fill_done),
        .inv_valid_i      (inv_valid_i),
        .inv_ready_o      (inv_ready_o),
        .inv_i            (inv_i),
        .inv_valid_o      (arr_inv_valid),
        .inv_o            (arr_inv),
        .inv_block_o      (inv_block)
    );

    icache_array i_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .re_i        (re),
        .rpc_i       (rpc),
        .tags_o      (tags),
        .valids_o    (valids),
        .data_o      (data),
        .wr_valid_i  (wr_valid),
        .wr_i        (wr),
        .inv_valid_i (arr_inv_valid),
        .inv_i       (arr_inv),
        .victim_o    (victim)
    );

endmodule

//--- rtl/sram_1r1w.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module sram_1r1w #(
    parameter int unsigned WIDTH = 32,
    parameter int unsigned DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     re_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [WIDTH-1:0]         rdata_o,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [WIDTH-1:0]         wdata_i
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read data holds while re_i is low
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the icache testbench; exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_icache -o Vtb_icache \
    && ./obj_dir/Vtb_icache \
    || exit 1
